// ==== common/palu_settings.svh ====
// ************************************************************
// Fixed sizes and register offsets of the packed ALU
// Offsets are byte addresses on the 5-bit Wishbone address
// ************************************************************
`ifndef PALU_SETTINGS_SVH
`define PALU_SETTINGS_SVH

`define PALU_XLEN 32
`define PALU_RLEN 64

`define PALU_REG_OPA    5'h00
`define PALU_REG_OPB    5'h04
`define PALU_REG_CTRL   5'h08
`define PALU_REG_STATUS 5'h0C
`define PALU_REG_RES_LO 5'h10
`define PALU_REG_RES_HI 5'h14

`endif

// ==== common/palu_pkg.sv ====
// ************************************************************
// Enumerations shared by the packed ALU blocks
// Reserved opcode and pack width codes are flagged by the core
// ************************************************************
`default_nettype none

package palu_pkg;

    typedef enum logic [3:0] {
        OP_ADD = 4'd0,
        OP_SUB = 4'd1,
        OP_SLL = 4'd2,
        OP_SRL = 4'd3,
        OP_ROL = 4'd4,
        OP_MUL = 4'd5
    } palu_op_e;

    // Number of lanes in a 32-bit operand
    typedef enum logic [2:0] {
        PW_1  = 3'd0,
        PW_2  = 3'd1,
        PW_4  = 3'd2,
        PW_8  = 3'd3,
        PW_16 = 3'd4
    } palu_pw_e;

    // Lane width in bits seen by the 64-bit adder
    typedef enum logic [2:0] {
        LANE_64 = 3'd0,
        LANE_32 = 3'd1,
        LANE_16 = 3'd2,
        LANE_8  = 3'd3,
        LANE_4  = 3'd4,
        LANE_2  = 3'd5
    } palu_lane_e;

    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_MUL  = 2'd1
    } palu_state_e;

endpackage

`default_nettype wire

// ==== hw/palu_adder.sv ====
// ************************************************************
// Packed 64-bit adder and subtractor, purely combinational
// Each lane wraps on its own width, no carry leaves a lane
// Reserved lane codes behave as one 64-bit lane
// ************************************************************
`timescale 1ns/1ps
`default_nettype none

module palu_adder (
    input  logic [63:0]          add_a,
    input  logic [63:0]          add_b,
    input  palu_pkg::palu_lane_e add_lane,
    input  logic                 add_sub,
    output logic [63:0]          add_c
);

    logic [6:0]  lmask;   // Lane width minus one
    logic [63:0] b_in;
    logic        carry;

    always_comb begin
        case (add_lane)
            palu_pkg::LANE_32: lmask = 7'd31;
            palu_pkg::LANE_16: lmask = 7'd15;
            palu_pkg::LANE_8:  lmask = 7'd7;
            palu_pkg::LANE_4:  lmask = 7'd3;
            palu_pkg::LANE_2:  lmask = 7'd1;
            default:           lmask = 7'd63;
        endcase
    end

    always_comb begin
        b_in  = add_sub ? ~add_b : add_b;   // Two's complement with the carry below
        carry = add_sub;
        for (int i = 0; i < 64; i++) begin
            if ((7'(i) & lmask) == 7'd0) begin
                carry = add_sub;            // Fresh carry at each lane start
            end
            add_c[i] = add_a[i] ^ b_in[i] ^ carry;
            carry    = (add_a[i] & b_in[i]) | (carry & (add_a[i] ^ b_in[i]));
        end
    end

endmodule

`default_nettype wire

// ==== hw/palu_shifter.sv ====
// ************************************************************
// Packed 32-bit shifter and left rotator, combinational
// Shift amount is taken modulo the lane width
// Non-shift opcodes return the rotate result
// ************************************************************
`timescale 1ns/1ps
`default_nettype none

module palu_shifter (
    input  logic [31:0]        shf_a,
    input  logic [4:0]         shf_sham,
    input  palu_pkg::palu_pw_e shf_pw,
    input  palu_pkg::palu_op_e shf_op,
    output logic [31:0]        shf_c
);

    logic [31:0] res [5];   // One candidate per pack width

    for (genvar k = 0; k < 5; k++) begin : g_pw
        localparam int W  = 32 >> k;
        localparam int SB = $clog2(W);
        for (genvar l = 0; l < (1 << k); l++) begin : g_lane
            logic [W-1:0]   lane;
            logic [SB-1:0]  sh;
            logic [2*W-1:0] dbl;

            assign lane = shf_a[l*W +: W];
            assign sh   = shf_sham[SB-1:0];     // Modulo lane width
            assign dbl  = {lane, lane} << sh;   // Upper half is the rotation
            assign res[k][l*W +: W] =
                (shf_op == palu_pkg::OP_SLL) ? lane << sh :
                (shf_op == palu_pkg::OP_SRL) ? lane >> sh : dbl[2*W-1:W];
        end
    end

    always_comb begin
        case (shf_pw)
            palu_pkg::PW_1:  shf_c = res[0];
            palu_pkg::PW_2:  shf_c = res[1];
            palu_pkg::PW_4:  shf_c = res[2];
            palu_pkg::PW_8:  shf_c = res[3];
            palu_pkg::PW_16: shf_c = res[4];
            default:         shf_c = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== palu_multiplier/palu_multiplier.sv ====
// ************************************************************
// Packed unsigned shift-and-add multiplier on an external adder
// Takes w cycles for lane width w while start stays high
// a, b and pw must hold steady for the whole operation
// Product of lane i lands in double-width slot i of result
// ************************************************************
`timescale 1ns/1ps
`default_nettype none

`include "palu_settings.svh"

module palu_multiplier (
    input  logic                   g_clk,
    input  logic                   g_resetn,
    input  logic                   start,
    output logic                   done,
    input  logic [`PALU_XLEN-1:0]  a,
    input  logic [`PALU_XLEN-1:0]  b,
    input  palu_pkg::palu_pw_e     pw,
    output logic [`PALU_RLEN-1:0]  add_a,
    output logic [`PALU_RLEN-1:0]  add_b,
    output palu_pkg::palu_lane_e   add_lane,
    input  logic [`PALU_RLEN-1:0]  add_c,
    output logic [`PALU_RLEN-1:0]  result
);

    logic [4:0]            ctr;        // Multiplier bit being processed
    logic [4:0]            ctr_stop;
    logic [`PALU_RLEN-1:0] spread_w [5];
    logic [`PALU_RLEN-1:0] mask_w [5];
    logic [`PALU_RLEN-1:0] spread;
    logic [`PALU_RLEN-1:0] mask;
    logic [`PALU_RLEN-1:0] mcand;
    logic [`PALU_RLEN-1:0] mcand_q;
    logic [`PALU_RLEN-1:0] acc;

    // Spread a into double-width slots and build the per-slot bit mask
    for (genvar k = 0; k < 5; k++) begin : g_pw
        localparam int W  = 32 >> k;
        localparam int SB = $clog2(W);
        for (genvar l = 0; l < (1 << k); l++) begin : g_lane
            assign spread_w[k][2*W*l +: 2*W] = {{W{1'b0}}, a[W*l +: W]};
            assign mask_w[k][2*W*l +: 2*W]   = {(2*W){b[W*l + ctr[SB-1:0]]}};
        end
    end

    always_comb begin
        case (pw)
            palu_pkg::PW_2: begin
                spread = spread_w[1]; mask = mask_w[1];
                add_lane = palu_pkg::LANE_32; ctr_stop = 5'd15;
            end
            palu_pkg::PW_4: begin
                spread = spread_w[2]; mask = mask_w[2];
                add_lane = palu_pkg::LANE_16; ctr_stop = 5'd7;
            end
            palu_pkg::PW_8: begin
                spread = spread_w[3]; mask = mask_w[3];
                add_lane = palu_pkg::LANE_8; ctr_stop = 5'd3;
            end
            palu_pkg::PW_16: begin
                spread = spread_w[4]; mask = mask_w[4];
                add_lane = palu_pkg::LANE_4; ctr_stop = 5'd1;
            end
            default: begin
                spread = spread_w[0]; mask = mask_w[0];
                add_lane = palu_pkg::LANE_64; ctr_stop = 5'd31;
            end
        endcase
    end

    assign mcand  = (ctr == 5'd0) ? spread : mcand_q;
    assign add_a  = mcand & mask;
    assign add_b  = (ctr == 5'd0) ? '0 : acc;     // First step starts from zero
    assign done   = start && (ctr == ctr_stop);
    assign result = done ? add_c : acc;           // Final sum is ready during done

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            ctr <= 5'd0;
        end else if (start) begin
            ctr <= done ? 5'd0 : ctr + 5'd1;
        end
    end

    always_ff @(posedge g_clk) begin
        if (start) begin
            acc     <= add_c;
            mcand_q <= mcand << 1;  // Stays inside its slot for w-1 steps
        end
    end

endmodule

`default_nettype wire

// ==== hw/palu_core.sv ====
// ************************************************************
// Command sequencer and result holder of the packed ALU
// Commands arriving while busy are dropped
// Add, sub and shifts finish at once, multiply takes w cycles
// ************************************************************
`timescale 1ns/1ps
`default_nettype none

`include "palu_settings.svh"

module palu_core (
    input  logic                   g_clk,
    input  logic                   g_resetn,
    input  logic                   cmd_valid,
    input  palu_pkg::palu_op_e     cmd_op,
    input  palu_pkg::palu_pw_e     cmd_pw,
    input  logic [4:0]             cmd_shamt,
    input  logic [`PALU_XLEN-1:0]  opa,
    input  logic [`PALU_XLEN-1:0]  opb,
    output logic                   busy,
    output logic                   error,
    output logic [`PALU_RLEN-1:0]  result
);

    palu_pkg::palu_state_e state;
    palu_pkg::palu_pw_e    mul_pw;     // Held for the whole multiply
    palu_pkg::palu_lane_e  dir_lane;
    palu_pkg::palu_lane_e  add_lane;
    palu_pkg::palu_lane_e  mul_add_lane;
    logic [`PALU_RLEN-1:0] add_a;
    logic [`PALU_RLEN-1:0] add_b;
    logic [`PALU_RLEN-1:0] add_c;
    logic                  add_sub;
    logic [`PALU_RLEN-1:0] mul_add_a;
    logic [`PALU_RLEN-1:0] mul_add_b;
    logic [`PALU_RLEN-1:0] mul_result;
    logic                  mul_start;
    logic                  mul_done;
    logic [`PALU_XLEN-1:0] shf_c;
    logic [`PALU_XLEN-1:0] dir_result;
    logic                  cmd_ok;

    assign cmd_ok = (cmd_op inside {palu_pkg::OP_ADD, palu_pkg::OP_SUB, palu_pkg::OP_SLL,
                                    palu_pkg::OP_SRL, palu_pkg::OP_ROL, palu_pkg::OP_MUL})
                 && (cmd_pw inside {palu_pkg::PW_1, palu_pkg::PW_2, palu_pkg::PW_4,
                                    palu_pkg::PW_8, palu_pkg::PW_16});

    assign busy      = (state == palu_pkg::ST_MUL);
    assign mul_start = busy;

    always_comb begin
        case (cmd_pw)
            palu_pkg::PW_2:  dir_lane = palu_pkg::LANE_16;
            palu_pkg::PW_4:  dir_lane = palu_pkg::LANE_8;
            palu_pkg::PW_8:  dir_lane = palu_pkg::LANE_4;
            palu_pkg::PW_16: dir_lane = palu_pkg::LANE_2;
            default:         dir_lane = palu_pkg::LANE_32;
        endcase
    end

    // Adder belongs to the multiplier while it runs
    always_comb begin
        if (busy) begin
            add_a    = mul_add_a;
            add_b    = mul_add_b;
            add_lane = mul_add_lane;
            add_sub  = 1'b0;
        end else begin
            add_a    = {32'b0, opa};
            add_b    = {32'b0, opb};
            add_lane = dir_lane;
            add_sub  = (cmd_op == palu_pkg::OP_SUB);
        end
    end

    assign dir_result = (cmd_op inside {palu_pkg::OP_ADD, palu_pkg::OP_SUB}) ?
                        add_c[`PALU_XLEN-1:0] : shf_c;

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            state  <= palu_pkg::ST_IDLE;
            error  <= 1'b0;
            result <= '0;
            mul_pw <= palu_pkg::PW_1;
        end else if (!busy) begin
            if (cmd_valid && !cmd_ok) begin
                error <= 1'b1;              // Result left untouched
            end else if (cmd_valid) begin
                error <= 1'b0;
                if (cmd_op == palu_pkg::OP_MUL) begin
                    state  <= palu_pkg::ST_MUL;
                    mul_pw <= cmd_pw;
                end else begin
                    result <= {32'b0, dir_result};
                end
            end
        end else if (mul_done) begin
            state  <= palu_pkg::ST_IDLE;
            result <= mul_result;
        end
    end

    palu_adder u_adder (
        .add_a   (add_a),
        .add_b   (add_b),
        .add_lane(add_lane),
        .add_sub (add_sub),
        .add_c   (add_c)
    );

    palu_shifter u_shifter (
        .shf_a   (opa),
        .shf_sham(cmd_shamt),
        .shf_pw  (cmd_pw),
        .shf_op  (cmd_op),
        .shf_c   (shf_c)
    );

    palu_multiplier u_mul (
        .g_clk   (g_clk),
        .g_resetn(g_resetn),
        .start   (mul_start),
        .done    (mul_done),
        .a       (opa),
        .b       (opb),
        .pw      (mul_pw),
        .add_a   (mul_add_a),
        .add_b   (mul_add_b),
        .add_lane(mul_add_lane),
        .add_c   (add_c),
        .result  (mul_result)
    );

endmodule

`default_nettype wire

// ==== hw/palu_wb_regs.sv ====
// ************************************************************
// Wishbone classic slave with the ALU register file
// Ack is one cycle after the request, exactly one cycle long
// Unmapped offsets are acked, reads give zero, writes dropped
// ************************************************************
`timescale 1ns/1ps
`default_nettype none

`include "palu_settings.svh"

module palu_wb_regs (
    input  logic                   g_clk,
    input  logic                   g_resetn,
    input  logic                   wb_cyc,
    input  logic                   wb_stb,
    input  logic                   wb_we,
    input  logic [4:0]             wb_adr,
    input  logic [`PALU_XLEN-1:0]  wb_dat_w,
    output logic [`PALU_XLEN-1:0]  wb_dat_r,
    output logic                   wb_ack,
    output logic [`PALU_XLEN-1:0]  opa,
    output logic [`PALU_XLEN-1:0]  opb,
    output logic                   cmd_valid,
    output palu_pkg::palu_op_e     cmd_op,
    output palu_pkg::palu_pw_e     cmd_pw,
    output logic [4:0]             cmd_shamt,
    input  logic                   busy,
    input  logic                   error,
    input  logic [`PALU_RLEN-1:0]  result
);

    logic                  req;
    logic                  ctrl_wr;
    logic [`PALU_XLEN-1:0] rd_data;

    assign req     = wb_cyc && wb_stb && !wb_ack;   // New request, not yet acked
    assign ctrl_wr = req && wb_we && (wb_adr == `PALU_REG_CTRL);

    always_comb begin
        case (wb_adr)
            `PALU_REG_OPA:    rd_data = opa;
            `PALU_REG_OPB:    rd_data = opb;
            `PALU_REG_STATUS: rd_data = {30'b0, error, busy};
            `PALU_REG_RES_LO: rd_data = result[31:0];
            `PALU_REG_RES_HI: rd_data = result[63:32];
            default:          rd_data = '0;   // CTRL is write-only
        endcase
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            wb_ack    <= 1'b0;
            cmd_valid <= 1'b0;
            cmd_op    <= palu_pkg::OP_ADD;
            cmd_pw    <= palu_pkg::PW_1;
            cmd_shamt <= 5'd0;
        end else begin
            wb_ack    <= req;
            cmd_valid <= ctrl_wr;   // Pulses with the ack
            if (ctrl_wr) begin
                cmd_op    <= palu_pkg::palu_op_e'(wb_dat_w[3:0]);
                cmd_pw    <= palu_pkg::palu_pw_e'(wb_dat_w[6:4]);
                cmd_shamt <= wb_dat_w[12:8];
            end
        end
    end

    // Operand storage and read data
    always_ff @(posedge g_clk) begin
        if (req && wb_we && (wb_adr == `PALU_REG_OPA)) begin
            opa <= wb_dat_w;
        end
        if (req && wb_we && (wb_adr == `PALU_REG_OPB)) begin
            opb <= wb_dat_w;
        end
        if (req) begin
            wb_dat_r <= rd_data;
        end
    end

endmodule

`default_nettype wire

// ==== hw/palu_top.sv ====
// ************************************************************
// Packed ALU top level, Wishbone classic slave on the outside
// Poll STATUS busy before reading a multiply result
// ************************************************************
`timescale 1ns/1ps
`default_nettype none

`include "palu_settings.svh"

module palu_top (
    input  logic                   g_clk,
    input  logic                   g_resetn,
    input  logic                   wb_cyc,
    input  logic                   wb_stb,
    input  logic                   wb_we,
    input  logic [4:0]             wb_adr,
    input  logic [`PALU_XLEN-1:0]  wb_dat_w,
    output logic [`PALU_XLEN-1:0]  wb_dat_r,
    output logic                   wb_ack
);

    logic [`PALU_XLEN-1:0] opa;
    logic [`PALU_XLEN-1:0] opb;
    logic                  cmd_valid;
    palu_pkg::palu_op_e    cmd_op;
    palu_pkg::palu_pw_e    cmd_pw;
    logic [4:0]            cmd_shamt;
    logic                  busy;
    logic                  error;
    logic [`PALU_RLEN-1:0] result;

    palu_wb_regs u_regs (
        .g_clk    (g_clk),
        .g_resetn (g_resetn),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .opa      (opa),
        .opb      (opb),
        .cmd_valid(cmd_valid),
        .cmd_op   (cmd_op),
        .cmd_pw   (cmd_pw),
        .cmd_shamt(cmd_shamt),
        .busy     (busy),
        .error    (error),
        .result   (result)
    );

    palu_core u_core (
        .g_clk    (g_clk),
        .g_resetn (g_resetn),
        .cmd_valid(cmd_valid),
        .cmd_op   (cmd_op),
        .cmd_pw   (cmd_pw),
        .cmd_shamt(cmd_shamt),
        .opa      (opa),
        .opb      (opb),
        .busy     (busy),
        .error    (error),
        .result   (result)
    );

endmodule

`default_nettype wire

// ==== verif/palu_tb.sv ====
// ************************************************************
// Testbench of the packed ALU, driven through the Wishbone slave
// Random operands come from a 16-bit Galois LFSR
// Multiply results are read only after STATUS busy clears
// ************************************************************
`timescale 1ns/1ps
`default_nettype none

`include "palu_settings.svh"

module palu_tb;

    localparam int max_ops       = 200;
    localparam int cycles_per_op = 40;
    localparam int timeout_limit = max_ops * cycles_per_op;
    localparam int num_rand      = 4;     // Random pairs per opcode and pack width

    logic        g_clk;
    logic        g_resetn;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [4:0]  wb_adr;
    logic [31:0] wb_dat_w;
    logic [31:0] wb_dat_r;
    logic        wb_ack;

    logic [15:0] lfsr;
    int          cycle_count;
    int          checks;
    int          errors;

    palu_top dut0 (
        .g_clk   (g_clk),
        .g_resetn(g_resetn),
        .wb_cyc  (wb_cyc),
        .wb_stb  (wb_stb),
        .wb_we   (wb_we),
        .wb_adr  (wb_adr),
        .wb_dat_w(wb_dat_w),
        .wb_dat_r(wb_dat_r),
        .wb_ack  (wb_ack)
    );

    initial begin
        g_clk = 1'b0;
        forever #4 g_clk = ~g_clk;
    end

    always @(posedge g_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", timeout_limit);
            $display("tests failed");
            $finish;
        end
    end

    // Taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic write_reg(input logic [4:0] adr, input logic [31:0] data);
        @(negedge g_clk);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = adr;
        wb_dat_w = data;
        do @(negedge g_clk); while (!wb_ack);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic read_reg(input logic [4:0] adr, output logic [31:0] data);
        @(negedge g_clk);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = adr;
        do @(negedge g_clk); while (!wb_ack);
        data   = wb_dat_r;   // Valid while ack is high
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
    endtask

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    function automatic logic [31:0] ctrl_word(input logic [3:0] op, input logic [2:0] pw,
                                              input logic [4:0] shamt);
        return {19'b0, shamt, 1'b0, pw, op};
    endfunction

    // Lane by lane reference of every operation
    function automatic logic [63:0] model_result(input logic [3:0] op, input logic [2:0] pw,
                                                 input logic [4:0] shamt,
                                                 input logic [31:0] a, input logic [31:0] b);
        int          w;
        int          sh;
        logic [63:0] mask;
        logic [63:0] la;
        logic [63:0] lb;
        logic [63:0] lr;
        logic [63:0] res;
        w    = 32 >> pw;
        sh   = shamt % w;
        mask = (64'd1 << w) - 64'd1;
        res  = '0;
        for (int i = 0; i < 32 / w; i++) begin
            la = ({32'b0, a} >> (i * w)) & mask;
            lb = ({32'b0, b} >> (i * w)) & mask;
            case (op)
                palu_pkg::OP_ADD: lr = (la + lb) & mask;
                palu_pkg::OP_SUB: lr = (la - lb) & mask;
                palu_pkg::OP_SLL: lr = (la << sh) & mask;
                palu_pkg::OP_SRL: lr = la >> sh;
                palu_pkg::OP_ROL: lr = ((la << sh) | (la >> (w - sh))) & mask;
                default:          lr = la * lb;   // Fits the double-width slot
            endcase
            if (op == palu_pkg::OP_MUL) begin
                res = res | (lr << (2 * i * w));
            end else begin
                res = res | (lr << (i * w));
            end
        end
        return res;
    endfunction

    task automatic wait_idle();
        logic [31:0] st;
        do read_reg(`PALU_REG_STATUS, st); while (st[0]);
    endtask

    task automatic run_op(input logic [3:0] op, input logic [2:0] pw, input logic [4:0] shamt,
                          input logic [31:0] a, input logic [31:0] b);
        logic [31:0] st;
        logic [31:0] lo;
        logic [31:0] hi;
        logic [63:0] exp;
        string       what;
        exp  = model_result(op, pw, shamt, a, b);
        what = $sformatf("op %0d pw %0d shamt %0d a %h b %h", op, pw, shamt, a, b);
        write_reg(`PALU_REG_OPA, a);
        write_reg(`PALU_REG_OPB, b);
        write_reg(`PALU_REG_CTRL, ctrl_word(op, pw, shamt));
        if (op == palu_pkg::OP_MUL) begin
            read_reg(`PALU_REG_STATUS, st);
            check_value({what, " first busy poll"}, 64'(st[0]), 64'd1);
            wait_idle();
        end
        read_reg(`PALU_REG_RES_LO, lo);
        read_reg(`PALU_REG_RES_HI, hi);
        check_value(what, {hi, lo}, exp);
    endtask

    initial begin
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] v;
        logic [31:0] lo;
        logic [31:0] hi;
        logic [63:0] prev;
        g_resetn    = 1'b0;
        wb_cyc      = 1'b0;
        wb_stb      = 1'b0;
        wb_we       = 1'b0;
        wb_adr      = 5'd0;
        wb_dat_w    = 32'd0;
        lfsr        = 16'd40276;
        cycle_count = 0;
        checks      = 0;
        errors      = 0;
        repeat (8) @(posedge g_clk);
        @(negedge g_clk);
        g_resetn = 1'b1;

        read_reg(`PALU_REG_STATUS, v);
        check_value("status after reset", 64'(v), 64'd0);
        read_reg(`PALU_REG_RES_LO, v);
        check_value("res_lo after reset", 64'(v), 64'd0);
        read_reg(`PALU_REG_RES_HI, v);
        check_value("res_hi after reset", 64'(v), 64'd0);

        for (int pw = 0; pw < 5; pw++) begin
            run_op(palu_pkg::OP_ADD, 3'(pw), 5'd0, 32'hFFFF_FFFF, 32'h5555_5555);  // Lane wrap
            for (int n = 0; n < num_rand; n++) begin
                take_bits(32, a);
                take_bits(32, b);
                run_op(palu_pkg::OP_ADD, 3'(pw), 5'd0, a, b);
                run_op(palu_pkg::OP_SUB, 3'(pw), 5'd0, a, b);
            end
        end

        for (int pw = 0; pw < 5; pw++) begin
            for (int n = 0; n < num_rand; n++) begin
                take_bits(32, a);
                take_bits(5, v);
                run_op(palu_pkg::OP_SLL, 3'(pw), v[4:0], a, 32'd0);
                take_bits(5, v);
                run_op(palu_pkg::OP_SRL, 3'(pw), v[4:0], a, 32'd0);
                take_bits(5, v);
                run_op(palu_pkg::OP_ROL, 3'(pw), v[4:0], a, 32'd0);
            end
        end

        for (int pw = 0; pw < 5; pw++) begin
            run_op(palu_pkg::OP_MUL, 3'(pw), 5'd0, 32'hFFFF_FFFF, 32'hFFFF_FFFF);
            for (int n = 0; n < num_rand; n++) begin
                take_bits(32, a);
                take_bits(32, b);
                run_op(palu_pkg::OP_MUL, 3'(pw), 5'd0, a, b);
            end
        end

        // Second command during a 32-cycle multiply must be dropped
        take_bits(32, a);
        take_bits(32, b);
        prev = model_result(palu_pkg::OP_MUL, 3'd0, 5'd0, a, b);
        write_reg(`PALU_REG_OPA, a);
        write_reg(`PALU_REG_OPB, b);
        write_reg(`PALU_REG_CTRL, ctrl_word(palu_pkg::OP_MUL, 3'd0, 5'd0));
        write_reg(`PALU_REG_CTRL, ctrl_word(palu_pkg::OP_MUL, 3'd4, 5'd0));  // Other lane layout
        read_reg(`PALU_REG_STATUS, v);
        check_value("busy after dropped command", 64'(v[0]), 64'd1);
        wait_idle();
        read_reg(`PALU_REG_RES_LO, lo);
        read_reg(`PALU_REG_RES_HI, hi);
        check_value("product after dropped command", {hi, lo}, prev);

        // Reserved opcode, then reserved pack width
        write_reg(`PALU_REG_CTRL, ctrl_word(4'hA, 3'd0, 5'd0));
        read_reg(`PALU_REG_STATUS, v);
        check_value("status after reserved opcode", 64'(v[1:0]), 64'd2);
        read_reg(`PALU_REG_RES_LO, lo);
        read_reg(`PALU_REG_RES_HI, hi);
        check_value("result after reserved opcode", {hi, lo}, prev);
        write_reg(`PALU_REG_CTRL, ctrl_word(palu_pkg::OP_ADD, 3'd6, 5'd0));
        read_reg(`PALU_REG_STATUS, v);
        check_value("status after reserved pw", 64'(v[1:0]), 64'd2);
        read_reg(`PALU_REG_RES_LO, lo);
        read_reg(`PALU_REG_RES_HI, hi);
        check_value("result after reserved pw", {hi, lo}, prev);
        take_bits(32, a);
        take_bits(32, b);
        run_op(palu_pkg::OP_ADD, 3'd2, 5'd0, a, b);
        read_reg(`PALU_REG_STATUS, v);
        check_value("status after valid command", 64'(v[1:0]), 64'd0);

        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== palu_top.f ====
+incdir+common
common/palu_pkg.sv
hw/palu_adder.sv
hw/palu_shifter.sv
palu_multiplier/palu_multiplier.sv
hw/palu_core.sv
hw/palu_wb_regs.sv
hw/palu_top.sv
verif/palu_tb.sv

// ==== Bender.yml ====
package:
  name: palu

export_include_dirs:
  - common

sources:
  - common/palu_pkg.sv
  - hw/palu_adder.sv
  - hw/palu_shifter.sv
  - palu_multiplier/palu_multiplier.sv
  - hw/palu_core.sv
  - hw/palu_wb_regs.sv
  - hw/palu_top.sv
  - target: test
    files:
      - verif/palu_tb.sv
